//--- hw/tmr_pkg.sv
package tmr_pkg;

  // Redundancy and datapath widths
  localparam int unsigned NumReplicas = 3;
  localparam int unsigned AccWidth    = 32;
  localparam int unsigned CountWidth  = 8;
  localparam int unsigned ShiftWidth  = 5;  // Rotate amount and fault bit index
  localparam int unsigned StateWidth  = AccWidth + CountWidth;

  typedef enum logic [1:0] {
    OP_ADD  = 2'b00,
    OP_XOR  = 2'b01,
    OP_ROTL = 2'b10,  // Rotate by operand[4:0]
    OP_LOAD = 2'b11
  } acc_op_e;

  // One command per cycle, valid acts as a strobe
  typedef struct packed {
    logic                valid;
    acc_op_e             op;
    logic [AccWidth-1:0] operand;
  } acc_cmd_t;

  // Upset request, flips acc[bit_sel] in every masked replica
  typedef struct packed {
    logic [NumReplicas-1:0] replica_mask;
    logic [ShiftWidth-1:0]  bit_sel;
  } fault_req_t;

  // Architectural state of one replica
  typedef struct packed {
    logic [AccWidth-1:0]   acc;
    logic [CountWidth-1:0] count;  // Executed commands, wraps
  } acc_state_t;

  // Everything a replica sees from the fanout
  typedef struct packed {
    acc_cmd_t              cmd;
    logic                  inject;
    logic [ShiftWidth-1:0] inject_bit;
    logic                  resync;  // Take voted state as base
  } core_in_t;

endpackage

//--- hw/tmr_fanout.sv
module tmr_fanout import tmr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  acc_cmd_t                     cmd_i,
  input  fault_req_t                   fault_i,
  input  logic       [NumReplicas-1:0] mismatch_i,
  output core_in_t   [NumReplicas-1:0] core_in_o,
  output logic                         cmd_valid_o
);

  acc_cmd_t               cmd_q;
  fault_req_t             fault_q;
  logic [NumReplicas-1:0] resync_q;
  logic [NumReplicas-1:0] inject;

  // Input stage, one register shared by all replicas
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_q    <= '0;
      fault_q  <= '0;
      resync_q <= '0;
    end else begin
      cmd_q    <= cmd_i;
      fault_q  <= fault_i;
      resync_q <= mismatch_i;  // Disagreeing replica reloads next cycle
    end
  end

  // Per-replica inject strobes from the mask
  always_comb begin
    for (int i = 0; i < NumReplicas; i++) begin
      inject[i] = fault_q.replica_mask[i];
    end
  end

  always_comb begin
    for (int i = 0; i < NumReplicas; i++) begin
      core_in_o[i].cmd        = cmd_q;        // Lockstep, same command everywhere
      core_in_o[i].inject     = inject[i];
      core_in_o[i].inject_bit = fault_q.bit_sel;
      core_in_o[i].resync     = resync_q[i];
    end
  end

  assign cmd_valid_o = cmd_q.valid;

endmodule

//--- hw/acc_core.sv
module acc_core import tmr_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  core_in_t   core_in_i,
  input  acc_state_t voted_state_i,
  output acc_state_t state_o
);

  acc_state_t state_q;
  acc_state_t state_d;
  acc_state_t base;
  acc_state_t exec;

  function automatic logic [AccWidth-1:0] rotl(
    input logic [AccWidth-1:0]   val,
    input logic [ShiftWidth-1:0] sh
  );
    logic [2*AccWidth-1:0] dbl;
    dbl = {val, val} << sh;
    return dbl[2*AccWidth-1:AccWidth];  // Upper half holds the rotated word
  endfunction

  // Apply one command to a state
  function automatic acc_state_t step(
    input acc_state_t cur,
    input acc_cmd_t   cmd
  );
    acc_state_t nxt;
    nxt = cur;
    if (cmd.valid) begin
      case (cmd.op)
        OP_ADD:  nxt.acc = cur.acc + cmd.operand;
        OP_XOR:  nxt.acc = cur.acc ^ cmd.operand;
        OP_ROTL: nxt.acc = rotl(cur.acc, cmd.operand[ShiftWidth-1:0]);
        OP_LOAD: nxt.acc = cmd.operand;
        default: nxt.acc = cur.acc;
      endcase
      nxt.count = cur.count + 1'b1;
    end
    return nxt;
  endfunction

  // Resync picks the voted state as starting point
  assign base = core_in_i.resync ? voted_state_i : state_q;

  assign exec = step(base, core_in_i.cmd);

  always_comb begin
    state_d = exec;
    if (core_in_i.inject) begin
      state_d.acc[core_in_i.inject_bit] = ~exec.acc[core_in_i.inject_bit];  // Upset
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // Resync leaves the replica in step with the vote
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (core_in_i.resync && !core_in_i.inject) |=> (state_q == voted_state_i))
    else $error("replica did not resync to voted state");

endmodule

//--- hw/tmr_voter.sv
module tmr_voter import tmr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         cmd_valid_i,
  input  acc_state_t [NumReplicas-1:0] replica_state_i,
  output acc_state_t                   voted_state_o,
  output logic       [NumReplicas-1:0] mismatch_o,
  output acc_state_t                   result_o,
  output logic                         result_valid_o,
  output logic                         tmr_error_o,
  output logic       [NumReplicas-1:0] tmr_mismatch_o,
  output logic                         tmr_failure_o
);

  logic [StateWidth-1:0]  voted_bits;
  logic [NumReplicas-1:0] mismatch;
  logic                   multi_fail;
  logic                   valid_q;  // Command executed by replicas this cycle

  // Bitwise majority over all replicas
  always_comb begin : majority
    int unsigned ones;
    for (int b = 0; b < StateWidth; b++) begin
      ones = 0;
      for (int r = 0; r < NumReplicas; r++) begin
        ones += replica_state_i[r][b];
      end
      voted_bits[b] = (ones > NumReplicas / 2);
    end
  end

  assign voted_state_o = acc_state_t'(voted_bits);

  always_comb begin
    for (int r = 0; r < NumReplicas; r++) begin
      mismatch[r] = (replica_state_i[r] != voted_state_o);
    end
  end

  assign mismatch_o = mismatch;

  // Vote cannot be trusted once two replicas disagree
  assign multi_fail = ($countones(mismatch) > 1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q        <= 1'b0;
      result_valid_o <= 1'b0;
      result_o       <= '0;
    end else begin
      valid_q        <= cmd_valid_i;
      result_valid_o <= valid_q;
      if (valid_q) begin
        result_o <= voted_state_o;
      end
    end
  end

  // A corrupted replica stays flagged until its resync lands,
  // so the error only fires on a newly disagreeing replica
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tmr_error_o    <= 1'b0;
      tmr_mismatch_o <= '0;
    end else begin
      tmr_error_o    <= |(mismatch & ~tmr_mismatch_o);
      tmr_mismatch_o <= mismatch;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tmr_failure_o <= 1'b0;
    end else if (multi_fail) begin
      tmr_failure_o <= 1'b1;  // Sticky until reset
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tmr_failure_o |=> tmr_failure_o)
    else $error("failure flag cleared without reset");

endmodule

//--- hw/tmr_acc_top.sv
module tmr_acc_top import tmr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  acc_cmd_t                     cmd_i,
  input  fault_req_t                   fault_i,
  output acc_state_t                   result_o,
  output logic                         result_valid_o,
  output logic                         tmr_error_o,
  output logic       [NumReplicas-1:0] tmr_mismatch_o,
  output logic                         tmr_failure_o
);

  core_in_t   [NumReplicas-1:0] core_in;
  acc_state_t [NumReplicas-1:0] replica_state;
  acc_state_t                   voted_state;
  logic       [NumReplicas-1:0] mismatch;
  logic                         cmd_valid;

  tmr_fanout i_fanout (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .cmd_i       ( cmd_i     ),
    .fault_i     ( fault_i   ),
    .mismatch_i  ( mismatch  ),
    .core_in_o   ( core_in   ),
    .cmd_valid_o ( cmd_valid )
  );

  // Lockstep replicas
  for (genvar i = 0; i < NumReplicas; i++) begin : gen_replicas
    acc_core i_core (
      .clk_i         ( clk_i            ),
      .arst_n_i      ( arst_n_i         ),
      .core_in_i     ( core_in[i]       ),
      .voted_state_i ( voted_state      ),
      .state_o       ( replica_state[i] )
    );
  end

  tmr_voter i_voter (
    .clk_i           ( clk_i          ),
    .arst_n_i        ( arst_n_i       ),
    .cmd_valid_i     ( cmd_valid      ),
    .replica_state_i ( replica_state  ),
    .voted_state_o   ( voted_state    ),
    .mismatch_o      ( mismatch       ),
    .result_o        ( result_o       ),
    .result_valid_o  ( result_valid_o ),
    .tmr_error_o     ( tmr_error_o    ),
    .tmr_mismatch_o  ( tmr_mismatch_o ),
    .tmr_failure_o   ( tmr_failure_o  )
  );

endmodule

//--- tests/tb_clkgen.sv
module tb_clkgen #(
  parameter int unsigned Period      = 40,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge once the reset cycles are done
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- tests/tb_tmr_acc.sv
module tb_tmr_acc import tmr_pkg::*; ();

  typedef struct packed {
    logic [31:0] due;
    acc_state_t  state;
  } expect_t;

  typedef struct packed {
    logic [31:0]            due;
    logic [NumReplicas-1:0] mask;
  } alarm_t;

  logic                   clk;
  logic                   arst_n;
  acc_cmd_t               cmd_drv = '0;
  fault_req_t             fault_drv = '0;
  acc_state_t             result;
  logic                   result_valid;
  logic                   tmr_error;
  logic [NumReplicas-1:0] tmr_mismatch;
  logic                   tmr_failure;

  acc_state_t  model = '0;       // Fault-free reference state
  logic [31:0] lfsr_q = 32'd24;
  int          ncyc = 0;         // Falling edges seen so far
  int          n_results = 0;
  int          fail_due = 32'h7fff_ffff;
  string       test_name = "reset";
  expect_t     res_q[$];
  alarm_t      err_q[$];

  tb_clkgen i_clkgen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  tmr_acc_top i_dut (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .cmd_i          ( cmd_drv      ),
    .fault_i        ( fault_drv    ),
    .result_o       ( result       ),
    .result_valid_o ( result_valid ),
    .tmr_error_o    ( tmr_error    ),
    .tmr_mismatch_o ( tmr_mismatch ),
    .tmr_failure_o  ( tmr_failure  )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  function automatic acc_cmd_t random_cmd();
    acc_cmd_t c;
    c.valid   = (rand_bits(2) != 0);  // About one idle cycle in four
    c.op      = acc_op_e'(2'(rand_bits(2)));
    c.operand = rand_bits(AccWidth);
    return c;
  endfunction

  function automatic acc_state_t ref_step(input acc_state_t s, input acc_cmd_t c);
    acc_state_t n;
    int         sh;
    n = s;
    sh = c.operand[4:0];
    if (c.valid) begin
      case (c.op)
        OP_ADD:  n.acc = s.acc + c.operand;
        OP_XOR:  n.acc = s.acc ^ c.operand;
        OP_ROTL: n.acc = (sh == 0) ? s.acc : ((s.acc << sh) | (s.acc >> (32 - sh)));
        default: n.acc = c.operand;
      endcase
      n.count = s.count + 8'd1;
    end
    return n;
  endfunction

  // Result and error pulse both show up on the fourth falling edge after driving
  task automatic drive_cycle(input acc_cmd_t cmd, input fault_req_t flt, input logic flip,
                             input logic [NumReplicas-1:0] err_mask, output int idx);
    expect_t e;
    alarm_t  a;
    @(posedge clk);
    cmd_drv   <= cmd;
    fault_drv <= flt;
    idx = ncyc;
    model = ref_step(model, cmd);
    if (flip) begin
      model.acc[flt.bit_sel] = ~model.acc[flt.bit_sel];  // Outvoted majority wins
    end
    if (cmd.valid) begin
      e.due   = idx + 4;
      e.state = model;
      res_q.push_back(e);
    end
    if (err_mask != '0) begin
      a.due  = idx + 4;
      a.mask = err_mask;
      err_q.push_back(a);
    end
  endtask

  always @(negedge clk) begin : compare_proc
    expect_t e;
    alarm_t  a;
    ncyc = ncyc + 1;
    if (arst_n) begin
      if (result_valid) begin
        assert (res_q.size() > 0)
          else abort_run($sformatf("result_valid_o pulsed with no command pending in %s",
                                   test_name));
        e = res_q.pop_front();
        n_results++;
        assert (e.due == ncyc)
          else abort_run($sformatf("ERR %s result cycle expected %0d actual %0d",
                                   test_name, e.due, ncyc));
        assert (result == e.state)
          else abort_run($sformatf("ERR %s result expected %h actual %h",
                                   test_name, e.state, result));
        assert (result.count == n_results[7:0])
          else abort_run($sformatf("ERR %s count expected %0d actual %0d",
                                   test_name, n_results[7:0], result.count));
      end else if (res_q.size() > 0 && res_q[0].due <= ncyc) begin
        abort_run($sformatf("result_valid_o never came for a command in %s", test_name));
      end
      if (tmr_error) begin
        assert (err_q.size() > 0)
          else abort_run($sformatf("tmr_error_o pulsed without an injected fault in %s",
                                   test_name));
        a = err_q.pop_front();
        assert (a.due == ncyc)
          else abort_run($sformatf("ERR %s error cycle expected %0d actual %0d",
                                   test_name, a.due, ncyc));
        assert (tmr_mismatch == a.mask)
          else abort_run($sformatf("ERR %s mismatch expected %b actual %b",
                                   test_name, a.mask, tmr_mismatch));
      end else if (err_q.size() > 0 && err_q[0].due <= ncyc) begin
        abort_run($sformatf("tmr_error_o did not pulse after a fault in %s", test_name));
      end
      assert (tmr_failure == (ncyc >= fail_due))
        else abort_run($sformatf("ERR %s failure expected %b actual %b",
                                 test_name, (ncyc >= fail_due), tmr_failure));
    end
  end

  initial begin : stimulus
    fault_req_t            flt;
    logic [ShiftWidth-1:0] bit_a;
    int                    t;
    int                    r;
    int                    idx;
    int                    issued;
    for (t = 0; t < 20 && !arst_n; t++) begin
      @(posedge clk);
    end
    if (!arst_n) begin
      abort_run("reset was never released");
    end
    @(negedge clk);
    assert (result == '0)
      else abort_run($sformatf("ERR %s result expected %h actual %h", test_name, '0, result));
    assert ({result_valid, tmr_error, tmr_mismatch, tmr_failure} == '0)
      else abort_run($sformatf("ERR %s status expected %b actual %b", test_name, 6'b0,
                               {result_valid, tmr_error, tmr_mismatch, tmr_failure}));

    test_name = "random_stream";
    issued = 0;
    for (t = 0; t < 1000 && issued < 200; t++) begin
      drive_cycle(random_cmd(), '0, 1'b0, '0, idx);
      issued = n_results + res_q.size();
    end
    if (issued < 200) begin
      abort_run("random stream did not reach 200 commands");
    end

    for (r = 0; r < NumReplicas; r++) begin
      test_name = "single_fault";
      flt.replica_mask = NumReplicas'(1) << r;
      flt.bit_sel      = ShiftWidth'(rand_bits(ShiftWidth));
      drive_cycle(random_cmd(), flt, 1'b0, flt.replica_mask, idx);
      repeat (3) drive_cycle(random_cmd(), '0, 1'b0, '0, idx);
      test_name = "resync";
      repeat (10) drive_cycle(random_cmd(), '0, 1'b0, '0, idx);
      @(negedge clk);
      assert (tmr_mismatch == '0)
        else abort_run($sformatf("ERR %s mismatch expected %b actual %b",
                                 test_name, 3'b000, tmr_mismatch));
    end

    test_name = "double_fault";
    flt.replica_mask = 3'b011;
    flt.bit_sel      = ShiftWidth'(rand_bits(ShiftWidth));
    drive_cycle(random_cmd(), flt, 1'b1, 3'b100, idx);  // Only replica 2 stays healthy
    repeat (12) drive_cycle(random_cmd(), '0, 1'b0, '0, idx);

    // Two replicas off the vote at once, in different bits
    bit_a = ShiftWidth'(rand_bits(ShiftWidth));
    flt.replica_mask = 3'b001;
    flt.bit_sel      = bit_a;
    drive_cycle(random_cmd(), flt, 1'b0, 3'b001, idx);
    flt.replica_mask = 3'b010;
    flt.bit_sel      = bit_a + 1'b1;
    drive_cycle('0, flt, 1'b0, 3'b011, idx);  // Idle, so replica 0 keeps its flipped bit
    fail_due = idx + 4;
    repeat (12) drive_cycle(random_cmd(), '0, 1'b0, '0, idx);

    test_name = "drain";
    for (t = 0; t < 20 && (res_q.size() > 0 || err_q.size() > 0); t++) begin
      drive_cycle('0, '0, 1'b0, '0, idx);
    end
    if (res_q.size() > 0 || err_q.size() > 0) begin
      abort_run("expected results or error pulses still outstanding at the end");
    end
    @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- files.f
hw/tmr_pkg.sv
hw/tmr_fanout.sv
hw/acc_core.sv
hw/tmr_voter.sv
hw/tmr_acc_top.sv
tests/tb_clkgen.sv
tests/tb_tmr_acc.sv
